//--- source/decode_pkg.sv
package decode_pkg;

  typedef logic [31:0] word_t;

  localparam int INST_W     = 32;
  localparam int OPCODE_W   = 6;
  localparam int GREG_ID_W  = 4;
  localparam int PREG_ID_W  = 2;
  localparam int GREG_COUNT = 16;
  localparam int PREG_COUNT = 4;

  // instruction field positions
  localparam int PSET_BIT = 31;
  localparam int PID_HI   = 30;
  localparam int PID_LO   = 29;
  localparam int OPC_HI   = 28;
  localparam int OPC_LO   = 23;
  localparam int Z_HI     = 22; // also the alternative X
  localparam int Z_LO     = 19;
  localparam int Y_HI     = 18;
  localparam int Y_LO     = 15;
  localparam int X_HI     = 14;
  localparam int X_LO     = 11;
  localparam int I15_HI   = 14;
  localparam int J23_HI   = 22;
  localparam int I19_HI   = 18;

  typedef enum logic [OPCODE_W-1:0] {
    OP_NOP  = 6'h00,
    OP_NEG  = 6'h05, OP_NOT  = 6'h06,
    OP_AND  = 6'h07, OP_OR   = 6'h08, OP_XOR  = 6'h09,
    OP_ADD  = 6'h0a, OP_SUB  = 6'h0b, OP_MUL  = 6'h0c, OP_DIV  = 6'h0d,
    OP_MOD  = 6'h0e, OP_SHL  = 6'h0f, OP_SHR  = 6'h10,
    OP_ANDI = 6'h11, OP_ORI  = 6'h12, OP_XORI = 6'h13,
    OP_ADDI = 6'h14, OP_SUBI = 6'h15, OP_MULI = 6'h16, OP_DIVI = 6'h17,
    OP_MODI = 6'h18, OP_SHLI = 6'h19, OP_SHRI = 6'h1a,
    OP_JALI = 6'h1b, OP_JALR = 6'h1c, OP_JMPI = 6'h1d, OP_JMPR = 6'h1e,
    OP_LD   = 6'h23, OP_ST   = 6'h24, OP_LDI  = 6'h25,
    OP_RTOP = 6'h26, OP_ANDP = 6'h27, OP_ORP  = 6'h28, OP_XORP = 6'h29,
    OP_NOTP = 6'h2a, OP_ISNEG = 6'h2b, OP_ISZERO = 6'h2c
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_NONE = 4'd0,
    ALU_ADD  = 4'd1, ALU_SUB  = 4'd2, ALU_MUL = 4'd3, ALU_DIV = 4'd4,
    ALU_MOD  = 4'd5, ALU_SHL  = 4'd6, ALU_SHR = 4'd7,
    ALU_AND  = 4'd8, ALU_OR   = 4'd9, ALU_XOR = 4'd10,
    ALU_NEG  = 4'd11, ALU_NOT = 4'd12, ALU_PASS = 4'd13, ALU_LINK = 4'd14
  } alu_op_e;

  // predicate unit reuses codes 1..7 when pf_or_i is 0
  localparam alu_op_e ALU_ANDP   = ALU_ADD;
  localparam alu_op_e ALU_ORP    = ALU_SUB;
  localparam alu_op_e ALU_XORP   = ALU_MUL;
  localparam alu_op_e ALU_NOTP   = ALU_DIV;
  localparam alu_op_e ALU_RTOP   = ALU_MOD;
  localparam alu_op_e ALU_ISNEG  = ALU_SHL;
  localparam alu_op_e ALU_ISZERO = ALU_SHR;

  typedef enum logic [1:0] {
    EXT_NONE = 2'b00,
    EXT_I15  = 2'b01,
    EXT_J23  = 2'b10,
    EXT_I19  = 2'b11
  } ext_kind_e;

  typedef struct packed {
    logic      wb_gen;
    logic      wb_pred;
    logic      wb_from_mem; // load data instead of alu result
    logic      mem_write;
    logic      mem_read;
    logic      link;
    logic      src2_imm;
    alu_op_e   alu_op;
    logic      pf_or_i;     // 1 integer unit, 0 predicate unit
    logic      jump_reg;
    logic      jump;
    ext_kind_e ext_kind;
    logic      reg_id_sel;  // x id from the z field
  } ctrl_t;

  localparam word_t GREG_RESET [GREG_COUNT] = '{
    32'd0,  32'd1,  32'd2,  32'd3,
    32'd4,  32'd5,  32'd6,  32'd7,
    32'd8,  32'd9,  32'd10, 32'd11,
    32'd12, 32'd13, 32'd14, 32'd15
  };

  localparam bit PREG_RESET [PREG_COUNT] = '{1'b1, 1'b1, 1'b0, 1'b0};

endpackage

//--- source/bank_if.sv
`timescale 1ns/1ps

interface bank_if #(
  parameter type entry_t = logic,
  parameter int  ID_W    = 2
);
  logic [ID_W-1:0] rd_x_id;
  logic [ID_W-1:0] rd_y_id;
  logic [ID_W-1:0] rd_g_id; // guard look-up
  entry_t          rd_x;
  entry_t          rd_y;
  entry_t          rd_g;
  logic            wr_en;
  logic [ID_W-1:0] wr_id;
  entry_t          wr_data;

  modport bank (input rd_x_id, rd_y_id, rd_g_id, wr_en, wr_id, wr_data,
                output rd_x, rd_y, rd_g);

  modport user (output rd_x_id, rd_y_id, rd_g_id, wr_en, wr_id, wr_data,
                input rd_x, rd_y, rd_g);

endinterface

//--- source/control_decoder.sv
`timescale 1ns/1ps

module control_decoder (
  input  decode_pkg::opcode_e opcode,
  output decode_pkg::ctrl_t   ctrl
);
  import decode_pkg::*;

  always_comb
  begin
    ctrl = '0; // nop word, float opcodes land here too
    case (opcode)
      OP_LD:
      begin
        ctrl.wb_gen      = 1'b1;
        ctrl.wb_from_mem = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.src2_imm    = 1'b1;
        ctrl.pf_or_i     = 1'b1;
        ctrl.ext_kind    = EXT_I15;
      end
      OP_ST:
      begin
        ctrl.mem_write  = 1'b1;
        ctrl.src2_imm   = 1'b1;
        ctrl.pf_or_i    = 1'b1;
        ctrl.ext_kind   = EXT_I15;
        ctrl.reg_id_sel = 1'b1; // store data reg sits in z field
      end
      OP_ANDP, OP_ORP, OP_XORP, OP_NOTP, OP_RTOP, OP_ISNEG, OP_ISZERO:
      begin
        ctrl.wb_pred = 1'b1;
      end
      OP_LDI:
      begin
        ctrl.wb_gen   = 1'b1;
        ctrl.src2_imm = 1'b1;
        ctrl.pf_or_i  = 1'b1;
        ctrl.ext_kind = EXT_I19;
      end
      OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI, OP_SHLI, OP_SHRI,
      OP_ANDI, OP_ORI, OP_XORI:
      begin
        ctrl.wb_gen   = 1'b1;
        ctrl.src2_imm = 1'b1;
        ctrl.pf_or_i  = 1'b1;
        ctrl.ext_kind = EXT_I15;
      end
      OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_MOD, OP_SHL, OP_SHR,
      OP_AND, OP_OR, OP_XOR, OP_NEG, OP_NOT:
      begin
        ctrl.wb_gen  = 1'b1;
        ctrl.pf_or_i = 1'b1;
      end
      OP_JMPI:
      begin
        ctrl.jump     = 1'b1;
        ctrl.ext_kind = EXT_J23;
      end
      OP_JMPR:
      begin
        ctrl.jump       = 1'b1;
        ctrl.jump_reg   = 1'b1;
        ctrl.reg_id_sel = 1'b1;
      end
      OP_JALI:
      begin
        ctrl.wb_gen   = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.pf_or_i  = 1'b1;
        ctrl.jump     = 1'b1;
        ctrl.ext_kind = EXT_I19;
      end
      OP_JALR:
      begin
        ctrl.wb_gen   = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.pf_or_i  = 1'b1;
        ctrl.jump     = 1'b1;
        ctrl.jump_reg = 1'b1;
      end
      default:
      begin
        ctrl = '0;
      end
    endcase

    case (opcode)
      OP_LD, OP_ST, OP_ADDI, OP_ADD: ctrl.alu_op = ALU_ADD;
      OP_SUBI, OP_SUB:               ctrl.alu_op = ALU_SUB;
      OP_MULI, OP_MUL:               ctrl.alu_op = ALU_MUL;
      OP_DIVI, OP_DIV:               ctrl.alu_op = ALU_DIV;
      OP_MODI, OP_MOD:               ctrl.alu_op = ALU_MOD;
      OP_SHLI, OP_SHL:               ctrl.alu_op = ALU_SHL;
      OP_SHRI, OP_SHR:               ctrl.alu_op = ALU_SHR;
      OP_ANDI, OP_AND:               ctrl.alu_op = ALU_AND;
      OP_ORI, OP_OR:                 ctrl.alu_op = ALU_OR;
      OP_XORI, OP_XOR:               ctrl.alu_op = ALU_XOR;
      OP_NEG:                        ctrl.alu_op = ALU_NEG;
      OP_NOT:                        ctrl.alu_op = ALU_NOT;
      OP_LDI:                        ctrl.alu_op = ALU_PASS; // imm straight through
      OP_JALI, OP_JALR:              ctrl.alu_op = ALU_LINK;
      OP_ANDP:                       ctrl.alu_op = ALU_ANDP;
      OP_ORP:                        ctrl.alu_op = ALU_ORP;
      OP_XORP:                       ctrl.alu_op = ALU_XORP;
      OP_NOTP:                       ctrl.alu_op = ALU_NOTP;
      OP_RTOP:                       ctrl.alu_op = ALU_RTOP;
      OP_ISNEG:                      ctrl.alu_op = ALU_ISNEG;
      OP_ISZERO:                     ctrl.alu_op = ALU_ISZERO;
      default:                       ctrl.alu_op = ALU_NONE;
    endcase
  end

endmodule

//--- source/register_bank.sv
`timescale 1ns/1ps

module register_bank #(
  parameter type    entry_t                     = logic,
  parameter int     DEPTH                       = 4,
  parameter entry_t RESET_VALUES [DEPTH]        = '{default: '0}
) (
  input logic clk,
  input logic rst,
  bank_if.bank port
);

  entry_t regs [DEPTH];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        regs[i] <= RESET_VALUES[i]; // per-entry reset table
      end
    end
    else if (port.wr_en)
    begin
      regs[port.wr_id] <= port.wr_data;
    end
  end

  // no bypass, same-cycle reads see the old entry
  assign port.rd_x = regs[port.rd_x_id];
  assign port.rd_y = regs[port.rd_y_id];
  assign port.rd_g = regs[port.rd_g_id];

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               inst_valid,
  input  logic [decode_pkg::INST_W-1:0]      inst,
  input  decode_pkg::word_t                  pc_next,
  input  logic                               wb_gen_en,
  input  logic [decode_pkg::GREG_ID_W-1:0]   wb_gen_id,
  input  decode_pkg::word_t                  wb_gen_data,
  input  logic                               wb_pred_en,
  input  logic [decode_pkg::PREG_ID_W-1:0]   wb_pred_id,
  input  logic                               wb_pred_data,
  output logic                               out_valid,
  output decode_pkg::ctrl_t                  ctrl,
  output decode_pkg::word_t                  rx,
  output decode_pkg::word_t                  ry,
  output logic                               px,
  output logic                               py,
  output logic                               pval,
  output logic [decode_pkg::GREG_ID_W-1:0]   z_id,
  output logic [decode_pkg::GREG_ID_W-1:0]   x_id,
  output logic [decode_pkg::GREG_ID_W-1:0]   y_id,
  output decode_pkg::word_t                  imm,
  output decode_pkg::word_t                  jump_target
);
  import decode_pkg::*;

  opcode_e               opcode;
  ctrl_t                 dec_ctrl;
  logic [GREG_ID_W-1:0]  x_sel;
  logic [GREG_ID_W-1:0]  y_sel;
  logic [GREG_ID_W-1:0]  z_sel;
  word_t                 imm_ext;
  word_t                 target;
  logic                  guard;

  bank_if #(.entry_t(word_t), .ID_W(GREG_ID_W)) greg_bus ();
  bank_if #(.entry_t(bit),    .ID_W(PREG_ID_W)) preg_bus ();

  assign opcode = opcode_e'(inst[OPC_HI:OPC_LO]);

  control_decoder u_ctrl (
    .opcode (opcode),
    .ctrl   (dec_ctrl)
  );

  assign x_sel = dec_ctrl.reg_id_sel ? inst[Z_HI:Z_LO] : inst[X_HI:X_LO];
  assign y_sel = inst[Y_HI:Y_LO];
  assign z_sel = inst[Z_HI:Z_LO];

  assign greg_bus.rd_x_id = x_sel;
  assign greg_bus.rd_y_id = y_sel;
  assign greg_bus.rd_g_id = '0; // guard look-up only used on preds
  assign greg_bus.wr_en   = wb_gen_en;
  assign greg_bus.wr_id   = wb_gen_id;
  assign greg_bus.wr_data = wb_gen_data;

  assign preg_bus.rd_x_id = x_sel[PREG_ID_W-1:0];
  assign preg_bus.rd_y_id = y_sel[PREG_ID_W-1:0];
  assign preg_bus.rd_g_id = inst[PID_HI:PID_LO];
  assign preg_bus.wr_en   = wb_pred_en;
  assign preg_bus.wr_id   = wb_pred_id;
  assign preg_bus.wr_data = wb_pred_data;

  register_bank #(.entry_t(word_t), .DEPTH(GREG_COUNT), .RESET_VALUES(GREG_RESET)) gregs (
    .clk  (clk),
    .rst  (rst),
    .port (greg_bus.bank)
  );

  register_bank #(.entry_t(bit), .DEPTH(PREG_COUNT), .RESET_VALUES(PREG_RESET)) pregs (
    .clk  (clk),
    .rst  (rst),
    .port (preg_bus.bank)
  );

  always_comb
  begin
    case (dec_ctrl.ext_kind)
      EXT_I15: imm_ext = {{(31 - I15_HI){inst[I15_HI]}}, inst[I15_HI:0]};
      EXT_J23: imm_ext = {{(31 - J23_HI){inst[J23_HI]}}, inst[J23_HI:0]};
      EXT_I19: imm_ext = {{(31 - I19_HI){inst[I19_HI]}}, inst[I19_HI:0]};
      default: imm_ext = '0;
    endcase
  end

  assign target = pc_next + imm_ext; // pc-relative from next pc
  assign guard  = inst[PSET_BIT] ? preg_bus.rd_g : 1'b1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out_valid   <= 1'b0;
      ctrl        <= '0;
      rx          <= '0;
      ry          <= '0;
      px          <= 1'b0;
      py          <= 1'b0;
      pval        <= 1'b0;
      z_id        <= '0;
      x_id        <= '0;
      y_id        <= '0;
      imm         <= '0;
      jump_target <= '0;
    end
    else
    begin
      out_valid <= inst_valid;
      if (inst_valid) // hold outputs on idle cycles
      begin
        ctrl        <= dec_ctrl;
        rx          <= greg_bus.rd_x;
        ry          <= greg_bus.rd_y;
        px          <= preg_bus.rd_x;
        py          <= preg_bus.rd_y;
        pval        <= guard;
        z_id        <= z_sel;
        x_id        <= x_sel;
        y_id        <= y_sel;
        imm         <= imm_ext;
        jump_target <= target;
      end
    end
  end

endmodule

//--- tests/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// columns: stream, write-back kind/id/data, instruction word,
// expected ctrl, rx, ry, px, py, pval, imm, x_id, y_id, z_id

typedef enum logic [1:0] {WB_NONE, WB_GEN, WB_PRED} wb_kind_e;

typedef struct packed {
  logic        stream;  // follows the previous row with no idle cycle
  wb_kind_e    wb_kind; // applied in the idle cycle before the row
  logic [3:0]  wb_id;
  logic [31:0] wb_data;
  logic [31:0] inst;
  logic [16:0] ctrl;    // wb/mem/link/imm bits, alu_op, unit/jump bits, ext, id sel
  logic [31:0] rx;
  logic [31:0] ry;
  logic        px;
  logic        py;
  logic        pval;
  logic [31:0] imm;
  logic [3:0]  x_id;
  logic [3:0]  y_id;
  logic [3:0]  z_id;
} vec_t;

localparam int VEC_COUNT = 24;

localparam vec_t VECTORS [VEC_COUNT] = '{
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_ADD, 4'd1, 4'd9, 4'd5, 11'd0},
    {7'b1000000, ALU_ADD, 3'b100, EXT_NONE, 1'b0},
    32'd5, 32'd9, 1'b1, 1'b1, 1'b1, 32'h0, 4'd5, 4'd9, 4'd1},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_ADD, 4'd0, 4'd2, 4'd8, 11'd0},
    {7'b1000000, ALU_ADD, 3'b100, EXT_NONE, 1'b0},
    32'd8, 32'd2, 1'b1, 1'b0, 1'b1, 32'h0, 4'd8, 4'd2, 4'd0},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_LD, 4'd3, 4'd2, 15'h0010}, // ld
    {7'b1010101, ALU_ADD, 3'b100, EXT_I15, 1'b0},
    32'd0, 32'd2, 1'b1, 1'b0, 1'b1, 32'h10, 4'd0, 4'd2, 4'd3},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_ST, 4'd6, 4'd4, 15'h7ff8}, // x from z
    {7'b0001001, ALU_ADD, 3'b100, EXT_I15, 1'b1},
    32'd6, 32'd4, 1'b0, 1'b1, 1'b1, 32'hffff_fff8, 4'd6, 4'd4, 4'd6},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_ANDP, 4'd2, 4'd1, 4'd3, 11'd0},
    {7'b0100000, ALU_ANDP, 3'b000, EXT_NONE, 1'b0},
    32'd3, 32'd1, 1'b0, 1'b1, 1'b1, 32'h0, 4'd3, 4'd1, 4'd2},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_ISNEG, 4'd1, 4'd0, 4'd12, 11'd0},
    {7'b0100000, ALU_ISNEG, 3'b000, EXT_NONE, 1'b0},
    32'd12, 32'd0, 1'b1, 1'b1, 1'b1, 32'h0, 4'd12, 4'd0, 4'd1},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_ADDI, 4'd4, 4'd3, 15'h0123},
    {7'b1000001, ALU_ADD, 3'b100, EXT_I15, 1'b0},
    32'd0, 32'd3, 1'b1, 1'b0, 1'b1, 32'h123, 4'd0, 4'd3, 4'd4},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_ADDI, 4'd4, 4'd3, 15'h4000}, // negative
    {7'b1000001, ALU_ADD, 3'b100, EXT_I15, 1'b0},
    32'd8, 32'd3, 1'b1, 1'b0, 1'b1, 32'hffff_c000, 4'd8, 4'd3, 4'd4},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_XOR, 4'd2, 4'd14, 4'd11, 11'd0},
    {7'b1000000, ALU_XOR, 3'b100, EXT_NONE, 1'b0},
    32'd11, 32'd14, 1'b0, 1'b0, 1'b1, 32'h0, 4'd11, 4'd14, 4'd2},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_NEG, 4'd5, 4'd0, 4'd7, 11'd0},
    {7'b1000000, ALU_NEG, 3'b100, EXT_NONE, 1'b0},
    32'd7, 32'd0, 1'b0, 1'b1, 1'b1, 32'h0, 4'd7, 4'd0, 4'd5},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_JMPI, 23'h7ffff0},
    {7'b0000000, ALU_NONE, 3'b001, EXT_J23, 1'b0},
    32'd15, 32'd15, 1'b0, 1'b0, 1'b1, 32'hffff_fff0, 4'd15, 4'd15, 4'd15},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_JALR, 4'd0, 4'd0, 4'd10, 11'd0},
    {7'b1000010, ALU_LINK, 3'b111, EXT_NONE, 1'b0},
    32'd10, 32'd0, 1'b0, 1'b1, 1'b1, 32'h0, 4'd10, 4'd0, 4'd0},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, 6'h35, 4'd1, 4'd2, 4'd3, 11'd0}, // float
    17'h0,
    32'd3, 32'd2, 1'b0, 1'b0, 1'b1, 32'h0, 4'd3, 4'd2, 4'd1},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, 6'h3f, 4'd0, 4'd0, 4'd0, 11'd0},
    17'h0,
    32'd0, 32'd0, 1'b1, 1'b1, 1'b1, 32'h0, 4'd0, 4'd0, 4'd0},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_LDI, 4'd9, 19'h40001},
    {7'b1000001, ALU_PASS, 3'b100, EXT_I19, 1'b0},
    32'd0, 32'd8, 1'b1, 1'b1, 1'b1, 32'hfffc_0001, 4'd0, 4'd8, 4'd9},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b1, 2'd2, OP_ADD, 4'd0, 4'd1, 4'd2, 11'd0}, // guard p2
    {7'b1000000, ALU_ADD, 3'b100, EXT_NONE, 1'b0},
    32'd2, 32'd1, 1'b0, 1'b1, 1'b0, 32'h0, 4'd2, 4'd1, 4'd0},
  '{1'b0, WB_GEN, 4'd7, 32'ha5a5_0003, {1'b0, 2'd0, OP_ADD, 4'd0, 4'd7, 4'd7, 11'd0},
    {7'b1000000, ALU_ADD, 3'b100, EXT_NONE, 1'b0},
    32'ha5a5_0003, 32'ha5a5_0003, 1'b0, 1'b0, 1'b1, 32'h0, 4'd7, 4'd7, 4'd0},
  '{1'b0, WB_PRED, 4'd3, 32'h1, {1'b0, 2'd0, OP_ADD, 4'd0, 4'd7, 4'd3, 11'd0},
    {7'b1000000, ALU_ADD, 3'b100, EXT_NONE, 1'b0},
    32'd3, 32'ha5a5_0003, 1'b1, 1'b1, 1'b1, 32'h0, 4'd3, 4'd7, 4'd0},
  '{1'b0, WB_PRED, 4'd2, 32'h1, {1'b1, 2'd2, OP_ADD, 4'd0, 4'd1, 4'd2, 11'd0},
    {7'b1000000, ALU_ADD, 3'b100, EXT_NONE, 1'b0},
    32'd2, 32'd1, 1'b1, 1'b1, 1'b1, 32'h0, 4'd2, 4'd1, 4'd0},
  '{1'b0, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_ADDI, 4'd1, 4'd7, 15'h0005}, // stream
    {7'b1000001, ALU_ADD, 3'b100, EXT_I15, 1'b0},
    32'd0, 32'ha5a5_0003, 1'b1, 1'b1, 1'b1, 32'h5, 4'd0, 4'd7, 4'd1},
  '{1'b1, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_XOR, 4'd2, 4'd15, 4'd7, 11'd0},
    {7'b1000000, ALU_XOR, 3'b100, EXT_NONE, 1'b0},
    32'ha5a5_0003, 32'd15, 1'b1, 1'b1, 1'b1, 32'h0, 4'd7, 4'd15, 4'd2},
  '{1'b1, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_JMPI, 23'h000100},
    {7'b0000000, ALU_NONE, 3'b001, EXT_J23, 1'b0},
    32'd0, 32'd0, 1'b1, 1'b1, 1'b1, 32'h100, 4'd0, 4'd0, 4'd0},
  '{1'b1, WB_NONE, 4'd0, 32'h0, {1'b1, 2'd1, OP_ISNEG, 4'd0, 4'd5, 4'd4, 11'd0},
    {7'b0100000, ALU_ISNEG, 3'b000, EXT_NONE, 1'b0},
    32'd4, 32'd5, 1'b1, 1'b1, 1'b1, 32'h0, 4'd4, 4'd5, 4'd0},
  '{1'b1, WB_NONE, 4'd0, 32'h0, {1'b0, 2'd0, OP_LD, 4'd2, 4'd7, 15'h0800},
    {7'b1010101, ALU_ADD, 3'b100, EXT_I15, 1'b0},
    32'd1, 32'ha5a5_0003, 1'b1, 1'b1, 1'b1, 32'h800, 4'd1, 4'd7, 4'd2}
};

`endif

//--- tests/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
  import decode_pkg::*;

  `include "decode_vectors.svh"

  logic                 clk;
  logic                 rst;
  logic                 inst_valid;
  logic [INST_W-1:0]    inst;
  word_t                pc_next;
  logic                 wb_gen_en;
  logic [GREG_ID_W-1:0] wb_gen_id;
  word_t                wb_gen_data;
  logic                 wb_pred_en;
  logic [PREG_ID_W-1:0] wb_pred_id;
  logic                 wb_pred_data;
  logic                 out_valid;
  ctrl_t                ctrl;
  word_t                rx;
  word_t                ry;
  logic                 px;
  logic                 py;
  logic                 pval;
  logic [GREG_ID_W-1:0] z_id;
  logic [GREG_ID_W-1:0] x_id;
  logic [GREG_ID_W-1:0] y_id;
  word_t                imm;
  word_t                jump_target;

  integer seed;
  int     row;
  word_t  pcs [VEC_COUNT];

  decode_stage dut0 (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at time %0t: row %0d %s is %h, expected %h",
               $time, row, name, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic wait_for_output();
    int waited;
    waited = 0;
    while (out_valid !== 1'b1)
    begin
      if (waited >= 20)
      begin
        $display("timed out waiting for out_valid");
        $display("Simulation finished: FAIL");
        $fatal(1, "no decode result within 20 cycles");
      end
      else
      begin
        @(posedge clk);
        #1;
        waited++;
      end
    end
  endtask

  task automatic compare_outputs(input vec_t v, input word_t pc);
    check_value("ctrl", {15'd0, ctrl}, {15'd0, v.ctrl});
    check_value("rx", rx, v.rx);
    check_value("ry", ry, v.ry);
    check_value("px", {31'd0, px}, {31'd0, v.px});
    check_value("py", {31'd0, py}, {31'd0, v.py});
    check_value("pval", {31'd0, pval}, {31'd0, v.pval});
    check_value("imm", imm, v.imm);
    check_value("jump_target", jump_target, pc + v.imm); // pc-relative target
    check_value("x_id", {28'd0, x_id}, {28'd0, v.x_id});
    check_value("y_id", {28'd0, y_id}, {28'd0, v.y_id});
    check_value("z_id", {28'd0, z_id}, {28'd0, v.z_id});
  endtask

  initial
  begin
    seed         = 32'h1be0c0e2;
    row          = -1;
    rst          = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    pc_next      = '0;
    wb_gen_en    = 1'b0;
    wb_gen_id    = '0;
    wb_gen_data  = '0;
    wb_pred_en   = 1'b0;
    wb_pred_id   = '0;
    wb_pred_data = 1'b0;
    for (int i = 0; i < VEC_COUNT; i++)
    begin
      pcs[i] = $random(seed);
    end

    for (int c = 0; c < 4; c++)
    begin
      @(posedge clk);
      #1;
      check_value("out_valid in reset", {31'd0, out_valid}, 32'd0);
      check_value("ctrl in reset", {15'd0, ctrl}, 32'd0);
      check_value("rx in reset", rx, 32'd0);
    end
    rst = 1'b0;

    for (int i = 0; i < VEC_COUNT; i++)
    begin
      row = i;
      if (!VECTORS[i].stream)
      begin
        inst_valid   = 1'b0; // idle cycle carries the write-back if any
        wb_gen_en    = (VECTORS[i].wb_kind == WB_GEN);
        wb_gen_id    = VECTORS[i].wb_id;
        wb_gen_data  = VECTORS[i].wb_data;
        wb_pred_en   = (VECTORS[i].wb_kind == WB_PRED);
        wb_pred_id   = VECTORS[i].wb_id[PREG_ID_W-1:0];
        wb_pred_data = VECTORS[i].wb_data[0];
        @(posedge clk);
        #1;
        wb_gen_en  = 1'b0;
        wb_pred_en = 1'b0;
        check_value("idle out_valid", {31'd0, out_valid}, 32'd0);
        if (i > 0)
        begin
          check_value("held imm", imm, VECTORS[i-1].imm);
        end
      end
      inst_valid = 1'b1;
      inst       = VECTORS[i].inst;
      pc_next    = pcs[i];
      @(posedge clk);
      #1;
      if (VECTORS[i].stream)
      begin
        check_value("streamed out_valid", {31'd0, out_valid}, 32'd1);
      end
      else
      begin
        wait_for_output();
      end
      compare_outputs(VECTORS[i], pcs[i]);
    end

    inst_valid = 1'b0;
    @(posedge clk);
    #1;
    check_value("out_valid after stream", {31'd0, out_valid}, 32'd0);
    check_value("held jump_target", jump_target,
                pcs[VEC_COUNT-1] + VECTORS[VEC_COUNT-1].imm);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+tests
source/decode_pkg.sv
source/bank_if.sv
source/control_decoder.sv
source/register_bank.sv
source/decode_stage.sv
tests/decode_stage_tb.sv

//--- Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
